//--- proc16_defines.svh
/*
 * Core sizes for proc16. REG_CNT must be a power of two.
 * The PC counts words and wraps at 2**PC_W.
 */
`ifndef PROC16_DEFINES_SVH
`define PROC16_DEFINES_SVH

// Data path and instruction width
`define PROC16_WORD_W 16

// General purpose registers
`define PROC16_REG_CNT 8

// Instruction address bits, word addressed
`define PROC16_PC_W 8

// Data memory words, addresses wrap modulo this size
`define PROC16_DMEM_DEPTH 256

`endif

//--- isaPkg.sv
/*
 * proc16 instruction encoding. Opcode in bits 15..11.
 * Unlisted opcodes execute as NOP.
 */
`default_nettype none
`include "proc16_defines.svh"

package isaPkg;

   typedef logic [`PROC16_WORD_W-1:0] wordT;
   typedef logic [`PROC16_WORD_W-1:0] instrT;
   typedef logic [$clog2(`PROC16_REG_CNT)-1:0] regIdxT;
   typedef logic [`PROC16_PC_W-1:0] pcT;

   typedef enum logic [4:0] {
      OP_HALT = 5'd0,
      OP_NOP  = 5'd1,
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_XOR,
      OP_ADDI,
      OP_LD,
      OP_ST,
      OP_LBI
   } opcodeE;

   // Field positions
   localparam int opcHi = 15;
   localparam int opcLo = 11;
   localparam int rsLo = 8;
   localparam int rtLo = 5;
   localparam int rdLo = 2;
   localparam int imm5Hi = 4;
   localparam int imm8Hi = 7;

   localparam instrT nopInstr = {OP_NOP, {opcLo{1'b0}}};

   function automatic opcodeE opcodeOf(input instrT i);
      return opcodeE'(i[opcHi:opcLo]);
   endfunction

   // rs field, also the LBI destination
   function automatic regIdxT rsOf(input instrT i);
      return i[rsLo +: $bits(regIdxT)];
   endfunction

   // rt field, also the I-format destination and store source
   function automatic regIdxT rtOf(input instrT i);
      return i[rtLo +: $bits(regIdxT)];
   endfunction

   function automatic regIdxT rdOf(input instrT i);
      return i[rdLo +: $bits(regIdxT)];
   endfunction

   function automatic wordT imm5Of(input instrT i);
      return wordT'($signed(i[imm5Hi:0]));
   endfunction

   function automatic wordT imm8Of(input instrT i);
      return wordT'($signed(i[imm8Hi:0]));
   endfunction

endpackage

`default_nettype wire

//--- pipePkg.sv
/*
 * Pipeline control encodings shared by decode, hazard, execute
 * and memory. These are internal and not part of the ISA.
 */
`default_nettype none

package pipePkg;

   // PASSB hands the second operand through, used by LBI
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_PASSB
   } aluOpE;

   // Source of the value written back
   typedef enum logic {
      WB_ALU,
      WB_MEM
   } wbSelE;

   // Source of an execute operand
   typedef enum logic [1:0] {
      FWD_REGFILE,
      FWD_EXMEM,
      FWD_MEMWB
   } fwdSelE;

endpackage

`default_nettype wire

//--- fetchStage.sv
/*
 * PC and IF/ID register. instr must be valid in the same cycle
 * as instrAddr. PC freezes for good once haltSeen rises.
 */
`timescale 1ns/1ns
`default_nettype none

module fetchStage (
   input  wire logic          clk,
   input  wire logic          rst,
   input  wire logic          stall,
   input  wire logic          haltSeen,
   input  wire isaPkg::instrT instr,
   output isaPkg::pcT         instrAddr,
   output isaPkg::instrT      fetchedInstr
);
   import isaPkg::*;

   pcT pc;

   assign instrAddr = pc;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
         fetchedInstr <= nopInstr;
      end else begin
         if (!stall && !haltSeen) begin
            pc <= pc + 1'b1;
         end
         // Squash whatever follows a HALT
         if (haltSeen) begin
            fetchedInstr <= nopInstr;
         end else if (!stall) begin
            fetchedInstr <= instr;
         end
      end
   end

endmodule

`default_nettype wire

//--- decodeStage.sv
/*
 * Decoder, register file and ID/EX register. Register file is
 * write-through: a write is seen by a read in the same cycle.
 */
`timescale 1ns/1ns
`default_nettype none
`include "proc16_defines.svh"

module decodeStage (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           stall,
   input  wire isaPkg::instrT  fetchedInstr,
   input  wire logic           wbEn,
   input  wire isaPkg::regIdxT wbIdx,
   input  wire isaPkg::wordT   wbValue,
   output pipePkg::aluOpE      exAluOp,
   output pipePkg::wbSelE      exWbSel,
   output isaPkg::regIdxT      exRs,
   output isaPkg::regIdxT      exRt,
   output isaPkg::regIdxT      exRd,
   output isaPkg::wordT        exOpA,
   output isaPkg::wordT        exOpB,
   output isaPkg::wordT        exImm,
   output isaPkg::wordT        exStoreData,
   output logic                exUseImm,
   output logic                exRegWrite,
   output logic                exLoad,
   output logic                exStore,
   output logic                exHalt,
   output logic                haltSeen
);
   import isaPkg::*;
   import pipePkg::*;

   wordT regs [`PROC16_REG_CNT];

   regIdxT rsIdx;
   regIdxT rtIdx;
   regIdxT dstIdx;
   wordT readA;
   wordT readB;
   wordT imm;
   aluOpE aluOp;
   wbSelE wbSel;
   logic useImm;
   logic regWrite;
   logic isLoad;
   logic isStore;
   logic isHalt;
   logic bubble;

   assign rsIdx = rsOf(fetchedInstr);
   assign rtIdx = rtOf(fetchedInstr);

   always_ff @(posedge clk) begin
      if (wbEn) begin
         regs[wbIdx] <= wbValue;
      end
   end

   // Bypass the writeback port onto both reads
   assign readA = (wbEn && wbIdx == rsIdx) ? wbValue : regs[rsIdx];
   assign readB = (wbEn && wbIdx == rtIdx) ? wbValue : regs[rtIdx];

   always_comb begin
      aluOp = ALU_ADD;
      wbSel = WB_ALU;
      useImm = 1'b0;
      regWrite = 1'b0;
      isLoad = 1'b0;
      isStore = 1'b0;
      isHalt = 1'b0;
      imm = imm5Of(fetchedInstr);
      dstIdx = rtIdx;
      case (opcodeOf(fetchedInstr))
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            regWrite = 1'b1;
            dstIdx = rdOf(fetchedInstr);
            case (opcodeOf(fetchedInstr))
               OP_SUB: aluOp = ALU_SUB;
               OP_AND: aluOp = ALU_AND;
               OP_XOR: aluOp = ALU_XOR;
               default: aluOp = ALU_ADD;
            endcase
         end
         OP_ADDI: begin
            useImm = 1'b1;
            regWrite = 1'b1;
         end
         OP_LD: begin
            useImm = 1'b1;
            regWrite = 1'b1;
            isLoad = 1'b1;
            wbSel = WB_MEM;
         end
         // Address is rs + imm5, data comes from the rt field
         OP_ST: begin
            useImm = 1'b1;
            isStore = 1'b1;
         end
         OP_LBI: begin
            aluOp = ALU_PASSB;
            useImm = 1'b1;
            regWrite = 1'b1;
            imm = imm8Of(fetchedInstr);
            dstIdx = rsIdx;
         end
         OP_HALT: isHalt = 1'b1;
         default: ;
      endcase
   end

   // Load-use stall and post-HALT squash both turn into a bubble
   assign bubble = stall || haltSeen;

   always_ff @(posedge clk) begin
      if (rst) begin
         exAluOp <= ALU_ADD;
         exWbSel <= WB_ALU;
         exRs <= '0;
         exRt <= '0;
         exRd <= '0;
         exOpA <= '0;
         exOpB <= '0;
         exImm <= '0;
         exStoreData <= '0;
         exUseImm <= 1'b0;
         exRegWrite <= 1'b0;
         exLoad <= 1'b0;
         exStore <= 1'b0;
         exHalt <= 1'b0;
         haltSeen <= 1'b0;
      end else begin
         exAluOp <= aluOp;
         exWbSel <= wbSel;
         exRs <= rsIdx;
         exRt <= rtIdx;
         exRd <= dstIdx;
         exOpA <= readA;
         exOpB <= readB;
         exImm <= imm;
         exStoreData <= isStore ? readB : '0;
         exUseImm <= useImm;
         exRegWrite <= regWrite && !bubble;
         exLoad <= isLoad && !bubble;
         exStore <= isStore && !bubble;
         exHalt <= isHalt && !bubble;
         haltSeen <= haltSeen || (isHalt && !bubble);
      end
   end

endmodule

`default_nettype wire

//--- hazardUnit.sv
/*
 * Load-use stall and forwarding selects, purely combinational.
 * EX/MEM never holds a load with a consumer in ID/EX.
 */
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
   input  wire isaPkg::instrT  fetchedInstr,
   input  wire isaPkg::regIdxT exRd,
   input  wire logic           exRegWrite,
   input  wire logic           exLoad,
   input  wire isaPkg::regIdxT exRs,
   input  wire isaPkg::regIdxT exRt,
   input  wire isaPkg::regIdxT memRd,
   input  wire logic           memRegWrite,
   input  wire isaPkg::regIdxT wbIdx,
   input  wire logic           wbEn,
   output logic                stall,
   output pipePkg::fwdSelE     fwdA,
   output pipePkg::fwdSelE     fwdB
);
   import isaPkg::*;
   import pipePkg::*;

   logic readsRs;
   logic readsRt;

   always_comb begin
      readsRs = 1'b0;
      readsRt = 1'b0;
      case (opcodeOf(fetchedInstr))
         OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ST: begin
            readsRs = 1'b1;
            readsRt = 1'b1;
         end
         OP_ADDI, OP_LD: readsRs = 1'b1;
         default: ;
      endcase
   end

   // Load data is not ready until MEM/WB
   assign stall = exLoad && exRegWrite &&
                  ((readsRs && exRd == rsOf(fetchedInstr)) ||
                   (readsRt && exRd == rtOf(fetchedInstr)));

   // Youngest producer wins
   assign fwdA = (memRegWrite && memRd == exRs) ? FWD_EXMEM :
                 (wbEn && wbIdx == exRs)        ? FWD_MEMWB : FWD_REGFILE;
   assign fwdB = (memRegWrite && memRd == exRt) ? FWD_EXMEM :
                 (wbEn && wbIdx == exRt)        ? FWD_MEMWB : FWD_REGFILE;

endmodule

`default_nettype wire

//--- executeStage.sv
/*
 * Forwarding muxes, ALU and EX/MEM register.
 * Arithmetic wraps modulo 2**16, there is no carry or flag.
 */
`timescale 1ns/1ns
`default_nettype none

module executeStage (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire pipePkg::aluOpE  exAluOp,
   input  wire pipePkg::wbSelE  exWbSel,
   input  wire isaPkg::regIdxT  exRd,
   input  wire isaPkg::wordT    exOpA,
   input  wire isaPkg::wordT    exOpB,
   input  wire isaPkg::wordT    exImm,
   input  wire isaPkg::wordT    exStoreData,
   input  wire logic            exUseImm,
   input  wire logic            exRegWrite,
   input  wire logic            exLoad,
   input  wire logic            exStore,
   input  wire logic            exHalt,
   input  wire pipePkg::fwdSelE fwdA,
   input  wire pipePkg::fwdSelE fwdB,
   input  wire isaPkg::wordT    wbValue,
   output isaPkg::wordT         memResult,
   output isaPkg::wordT         memStoreData,
   output isaPkg::regIdxT       memRd,
   output pipePkg::wbSelE       memWbSel,
   output logic                 memRegWrite,
   output logic                 memLoad,
   output logic                 memStore,
   output logic                 memHalt
);
   import isaPkg::*;
   import pipePkg::*;

   wordT srcA;
   wordT srcB;
   wordT storeVal;
   wordT aluB;
   wordT aluOut;

   function automatic wordT pickOperand(input fwdSelE sel, input wordT fromRegs,
                                        input wordT fromExMem, input wordT fromMemWb);
      case (sel)
         FWD_EXMEM: return fromExMem;
         FWD_MEMWB: return fromMemWb;
         default: return fromRegs;
      endcase
   endfunction

   assign srcA = pickOperand(fwdA, exOpA, memResult, wbValue);
   assign srcB = pickOperand(fwdB, exOpB, memResult, wbValue);
   // Store source sits in the rt slot, so it follows fwdB
   assign storeVal = pickOperand(fwdB, exStoreData, memResult, wbValue);
   assign aluB = exUseImm ? exImm : srcB;

   always_comb begin
      case (exAluOp)
         ALU_ADD: aluOut = srcA + aluB;
         ALU_SUB: aluOut = srcA - aluB;
         ALU_AND: aluOut = srcA & aluB;
         ALU_XOR: aluOut = srcA ^ aluB;
         default: aluOut = aluB;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         memResult <= '0;
         memStoreData <= '0;
         memRd <= '0;
         memWbSel <= WB_ALU;
         memRegWrite <= 1'b0;
         memLoad <= 1'b0;
         memStore <= 1'b0;
         memHalt <= 1'b0;
      end else begin
         memResult <= aluOut;
         memStoreData <= storeVal;
         memRd <= exRd;
         memWbSel <= exWbSel;
         memRegWrite <= exRegWrite;
         memLoad <= exLoad;
         memStore <= exStore;
         memHalt <= exHalt;
      end
   end

endmodule

`default_nettype wire

//--- memoryStage.sv
/*
 * Data memory and MEM/WB register. Word addressed, the address is
 * the low bits of the ALU result. Memory has no reset.
 */
`timescale 1ns/1ns
`default_nettype none
`include "proc16_defines.svh"

module memoryStage (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire isaPkg::wordT   memResult,
   input  wire isaPkg::wordT   memStoreData,
   input  wire isaPkg::regIdxT memRd,
   input  wire pipePkg::wbSelE memWbSel,
   input  wire logic           memRegWrite,
   input  wire logic           memLoad,
   input  wire logic           memStore,
   input  wire logic           memHalt,
   output logic                wbValid,
   output isaPkg::regIdxT      wbReg,
   output isaPkg::wordT        wbData,
   output logic                halted
);
   import isaPkg::*;
   import pipePkg::*;

   localparam int addrW = $clog2(`PROC16_DMEM_DEPTH);

   wordT dmem [`PROC16_DMEM_DEPTH];
   logic [addrW-1:0] memAddr;
   wordT loadWord;

   assign memAddr = memResult[addrW-1:0];
   assign loadWord = memLoad ? dmem[memAddr] : '0;

   always_ff @(posedge clk) begin
      if (memStore) begin
         dmem[memAddr] <= memStoreData;
      end
   end

   // Load data lands in MEM/WB at the end of this cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         wbValid <= 1'b0;
         wbReg <= '0;
         wbData <= '0;
         halted <= 1'b0;
      end else begin
         wbValid <= memRegWrite;
         wbReg <= memRd;
         wbData <= (memWbSel == WB_MEM) ? loadWord : memResult;
         // Sticky until reset
         halted <= halted || memHalt;
      end
   end

endmodule

`default_nettype wire

//--- proc16.sv
/*
 * proc16 top. instr must answer instrAddr combinationally.
 * wbValid pulses once per register write, halted stays up till rst.
 */
`timescale 1ns/1ns
`default_nettype none

module proc16 (
   input  wire logic          clk,
   input  wire logic          rst,
   input  wire isaPkg::instrT instr,
   output isaPkg::pcT         instrAddr,
   output logic               wbValid,
   output isaPkg::regIdxT     wbReg,
   output isaPkg::wordT       wbData,
   output logic               halted
);
   import isaPkg::*;
   import pipePkg::*;

   // IF/ID
   instrT fetchedInstr;

   // Hazard control
   logic stall;
   logic haltSeen;
   fwdSelE fwdA;
   fwdSelE fwdB;

   // ID/EX
   aluOpE exAluOp;
   wbSelE exWbSel;
   regIdxT exRs;
   regIdxT exRt;
   regIdxT exRd;
   wordT exOpA;
   wordT exOpB;
   wordT exImm;
   wordT exStoreData;
   logic exUseImm;
   logic exRegWrite;
   logic exLoad;
   logic exStore;
   logic exHalt;

   // EX/MEM
   wordT memResult;
   wordT memStoreData;
   regIdxT memRd;
   wbSelE memWbSel;
   logic memRegWrite;
   logic memLoad;
   logic memStore;
   logic memHalt;

   fetchStage uFetch (
      .clk(clk), .rst(rst), .stall(stall), .haltSeen(haltSeen),
      .instr(instr), .instrAddr(instrAddr), .fetchedInstr(fetchedInstr)
   );

   // MEM/WB outputs double as the register file write port
   decodeStage uDecode (
      .clk(clk), .rst(rst), .stall(stall), .fetchedInstr(fetchedInstr),
      .wbEn(wbValid), .wbIdx(wbReg), .wbValue(wbData),
      .exAluOp(exAluOp), .exWbSel(exWbSel),
      .exRs(exRs), .exRt(exRt), .exRd(exRd),
      .exOpA(exOpA), .exOpB(exOpB), .exImm(exImm), .exStoreData(exStoreData),
      .exUseImm(exUseImm), .exRegWrite(exRegWrite), .exLoad(exLoad),
      .exStore(exStore), .exHalt(exHalt), .haltSeen(haltSeen)
   );

   hazardUnit uHazard (
      .fetchedInstr(fetchedInstr),
      .exRd(exRd), .exRegWrite(exRegWrite), .exLoad(exLoad),
      .exRs(exRs), .exRt(exRt),
      .memRd(memRd), .memRegWrite(memRegWrite),
      .wbIdx(wbReg), .wbEn(wbValid),
      .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
   );

   executeStage uExecute (
      .clk(clk), .rst(rst),
      .exAluOp(exAluOp), .exWbSel(exWbSel), .exRd(exRd),
      .exOpA(exOpA), .exOpB(exOpB), .exImm(exImm), .exStoreData(exStoreData),
      .exUseImm(exUseImm), .exRegWrite(exRegWrite), .exLoad(exLoad),
      .exStore(exStore), .exHalt(exHalt),
      .fwdA(fwdA), .fwdB(fwdB), .wbValue(wbData),
      .memResult(memResult), .memStoreData(memStoreData), .memRd(memRd),
      .memWbSel(memWbSel), .memRegWrite(memRegWrite), .memLoad(memLoad),
      .memStore(memStore), .memHalt(memHalt)
   );

   memoryStage uMemory (
      .clk(clk), .rst(rst),
      .memResult(memResult), .memStoreData(memStoreData), .memRd(memRd),
      .memWbSel(memWbSel), .memRegWrite(memRegWrite), .memLoad(memLoad),
      .memStore(memStore), .memHalt(memHalt),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .halted(halted)
   );

endmodule

`default_nettype wire

//--- proc16_checker.sv
/*
 * Port-level protocol checks for proc16, bound into every instance.
 * Failures go through $error and are counted in violations.
 */
`timescale 1ns/1ns
`default_nettype none

module proc16_checker (
   input wire logic       clk,
   input wire logic       rst,
   input wire isaPkg::pcT instrAddr,
   input wire logic       wbValid,
   input wire logic       halted
);
   import isaPkg::*;

   int violations = 0;

   // Reset values one cycle on
   assert property (@(posedge clk) rst |=> (!wbValid && !halted && instrAddr == '0))
      else begin
         $error("outputs not cleared after reset");
         violations++;
      end

   // halted is sticky
   assert property (@(posedge clk) disable iff (rst) halted |=> halted)
      else begin
         $error("halted fell without reset");
         violations++;
      end

   assert property (@(posedge clk) disable iff (rst) halted |=> $stable(instrAddr))
      else begin
         $error("instrAddr moved while halted");
         violations++;
      end

   assert property (@(posedge clk) disable iff (rst) halted |=> !wbValid)
      else begin
         $error("register write after halt");
         violations++;
      end

   // PC holds or steps by one word
   assert property (@(posedge clk) disable iff (rst)
      1'b1 |=> (instrAddr == $past(instrAddr) ||
                instrAddr == pcT'($past(instrAddr) + 1'b1)))
      else begin
         $error("instrAddr jumped");
         violations++;
      end

endmodule

bind proc16 proc16_checker chk (
   .clk(clk), .rst(rst), .instrAddr(instrAddr), .wbValid(wbValid), .halted(halted)
);

`default_nettype wire

//--- proc16_tb.sv
/*
 * Testbench for proc16. The ROM answers instrAddr one ns after each edge.
 * Random LD/ST use r0 as a zero base, and data memory persists over resets.
 */
`timescale 1ns/1ns
`default_nettype none
`include "proc16_defines.svh"

module proc16_tb;
   localparam logic [15:0] lfsrSeed = 16'd23521;
   localparam int randomPrograms = 20;
   localparam int programLen = 24;
   localparam int programCount = randomPrograms + 5;
   localparam int timeoutCycles = programCount * (programLen * 2 + 20);
   localparam int romDepth = 1 << `PROC16_PC_W;

   localparam logic [4:0] opHalt = 5'd0;
   localparam logic [4:0] opAdd = 5'd2;
   localparam logic [4:0] opSub = 5'd3;
   localparam logic [4:0] opAnd = 5'd4;
   localparam logic [4:0] opXor = 5'd5;
   localparam logic [4:0] opAddi = 5'd6;
   localparam logic [4:0] opLd = 5'd7;
   localparam logic [4:0] opSt = 5'd8;
   localparam logic [4:0] opLbi = 5'd9;
   localparam logic [4:0] opUnused = 5'd25;
   localparam logic [15:0] nopWord = 16'h0800;
   localparam logic [15:0] haltWord = 16'h0000;

   logic clk = 1'b0;
   logic rst = 1'b1;
   logic [`PROC16_WORD_W-1:0] instr = nopWord;
   logic [`PROC16_PC_W-1:0] instrAddr;
   logic wbValid;
   logic [2:0] wbReg;
   logic [`PROC16_WORD_W-1:0] wbData;
   logic halted;

   logic [15:0] rom [romDepth];
   logic [15:0] mReg [`PROC16_REG_CNT];
   logic [15:0] mMem [`PROC16_DMEM_DEPTH];
   bit memWritten [`PROC16_DMEM_DEPTH];
   logic [2:0] expReg [romDepth];
   logic [15:0] expVal [romDepth];
   int expCount = 0;
   int expStalls = 0;
   int wbSeen = 0;
   int stallSeen = 0;
   int cycles = 0;
   logic [15:0] lfsr = lfsrSeed;
   logic [`PROC16_PC_W-1:0] prevAddr = '0;
   logic addrLive = 1'b0;

   proc16 dut (
      .clk(clk), .rst(rst), .instr(instr), .instrAddr(instrAddr),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .halted(halted)
   );

   always #5 clk = ~clk;

   // Combinational ROM, refreshed just after each edge
   always @(posedge clk) begin
      #1;
      instr = rom[instrAddr];
   end

   task automatic reportMismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
      $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic reportFailure(input string what);
      $display("Run stopped at %0t ns: %s", $time, what);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   function automatic logic [15:0] nextLfsr(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per bit
   function automatic int randBits(input int n);
      int v;
      int i;
      v = 0;
      for (i = 0; i < n; i++) begin
         v = (v << 1) | lfsr[0];
         lfsr = nextLfsr(lfsr);
      end
      return v;
   endfunction

   function automatic logic [15:0] aluInstr(input logic [4:0] op, input int rd,
                                           input int rs, input int rt);
      return {op, rs[2:0], rt[2:0], rd[2:0], 2'b00};
   endfunction

   function automatic logic [15:0] immInstr(input logic [4:0] op, input int rt,
                                           input int rs, input int imm);
      return {op, rs[2:0], rt[2:0], imm[4:0]};
   endfunction

   function automatic logic [15:0] loadByteImm(input int rd, input int imm);
      return {opLbi, rd[2:0], imm[7:0]};
   endfunction

   // Does instruction w read register r in decode
   function automatic logic readsReg(input logic [15:0] w, input logic [2:0] r);
      case (w[15:11])
         opAdd, opSub, opAnd, opXor, opSt: return w[10:8] == r || w[7:5] == r;
         opAddi, opLd: return w[10:8] == r;
         default: return 1'b0;
      endcase
   endfunction

   function automatic void recordWrite(input logic [2:0] idx, input logic [15:0] val);
      mReg[idx] = val;
      expReg[expCount] = idx;
      expVal[expCount] = val;
      expCount++;
   endfunction

   // In-order ISA model, stops at the first HALT
   function automatic void runModel();
      int pc;
      logic done;
      logic [15:0] w;
      logic [15:0] nxt;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] i5;
      logic [7:0] addr;
      expCount = 0;
      expStalls = 0;
      pc = 0;
      done = 1'b0;
      while (!done && pc < romDepth) begin
         w = rom[pc];
         nxt = (pc + 1 < romDepth) ? rom[pc + 1] : nopWord;
         a = mReg[w[10:8]];
         b = mReg[w[7:5]];
         i5 = {{11{w[4]}}, w[4:0]};
         // Word address wraps at 256
         addr = a[7:0] + i5[7:0];
         case (w[15:11])
            opHalt: done = 1'b1;
            opAdd: recordWrite(w[4:2], a + b);
            opSub: recordWrite(w[4:2], a - b);
            opAnd: recordWrite(w[4:2], a & b);
            opXor: recordWrite(w[4:2], a ^ b);
            opAddi: recordWrite(w[7:5], a + i5);
            opLd: begin
               recordWrite(w[7:5], mMem[addr]);
               if (readsReg(nxt, w[7:5])) begin
                  expStalls++;
               end
            end
            opSt: mMem[addr] = b;
            opLbi: recordWrite(w[10:8], {{8{w[7]}}, w[7:0]});
            default: ;
         endcase
         pc++;
      end
   endfunction

   task automatic clearRom();
      int i;
      for (i = 0; i < romDepth; i++) begin
         rom[i] = nopWord;
      end
   endtask

   task automatic makeRandomProgram();
      int i;
      int kind;
      int rd;
      int rs;
      int rt;
      int imm;
      logic [7:0] addr;
      // r0 is the zero memory base and never a random destination
      rom[0] = loadByteImm(0, 0);
      for (i = 1; i < `PROC16_REG_CNT; i++) begin
         rom[i] = loadByteImm(i, randBits(8));
      end
      for (i = `PROC16_REG_CNT; i < programLen - 1; i++) begin
         kind = randBits(4);
         rs = randBits(3);
         rt = randBits(3);
         rd = randBits(3);
         if (rd == 0) begin
            rd = 7;
         end
         imm = randBits(5);
         addr = {{3{imm[4]}}, imm[4:0]};
         // Never load a word that was not stored yet
         if (kind >= 7 && kind <= 9 && !memWritten[addr]) begin
            kind = 10;
         end
         case (kind)
            0, 1: rom[i] = aluInstr(opAdd, rd, rs, rt);
            2: rom[i] = aluInstr(opSub, rd, rs, rt);
            3: rom[i] = aluInstr(opAnd, rd, rs, rt);
            4: rom[i] = aluInstr(opXor, rd, rs, rt);
            5, 6: rom[i] = immInstr(opAddi, rd, rs, imm);
            7, 8, 9: rom[i] = immInstr(opLd, rd, 0, imm);
            10, 11, 12: begin
               rom[i] = immInstr(opSt, rt, 0, imm);
               memWritten[addr] = 1'b1;
            end
            13: rom[i] = loadByteImm(rd, randBits(8));
            14: rom[i] = nopWord;
            default: rom[i] = {opUnused, 11'h2A5};
         endcase
      end
      rom[programLen - 1] = haltWord;
   endtask

   // Reset, run the loaded ROM to HALT, then check the totals
   task automatic runProgram();
      wbSeen = 0;
      stallSeen = 0;
      runModel();
      repeat (4) @(posedge clk);
      #1 rst = 1'b0;
      do @(negedge clk); while (!halted);
      repeat (3) @(negedge clk);
      assert (wbSeen == expCount)
         else reportMismatch("writeback count", expCount, wbSeen);
      // One hold per load-use pair plus the freeze behind HALT
      assert (stallSeen == expStalls + 1)
         else reportMismatch("instrAddr hold cycles", expStalls + 1, stallSeen);
      @(posedge clk);
      #1 rst = 1'b1;
      clearRom();
   endtask

   always @(negedge clk) begin
      cycles++;
      if (cycles > timeoutCycles) begin
         reportFailure("the programs did not finish within the cycle limit");
      end
   end

   // Writeback and fetch monitor
   always @(negedge clk) begin
      if (dut.chk.violations != 0) begin
         reportFailure("a port assertion in the checker failed");
      end
      if (!rst) begin
         if (wbValid) begin
            assert (wbSeen < expCount)
               else reportFailure("a register write came after all expected writes");
            assert (wbReg == expReg[wbSeen])
               else reportMismatch("wbReg", expReg[wbSeen], wbReg);
            assert (wbData == expVal[wbSeen])
               else reportMismatch("wbData", expVal[wbSeen], wbData);
            wbSeen++;
         end
         if (!halted && addrLive && instrAddr == prevAddr) begin
            stallSeen++;
         end
      end
      prevAddr = instrAddr;
      addrLive = !rst;
   end

   initial begin
      int p;
      clearRom();
      // Dependent chain over both forwarding paths
      rom[0] = loadByteImm(1, 8'hB3);
      rom[1] = immInstr(opAddi, 2, 1, -3);
      rom[2] = aluInstr(opAdd, 3, 2, 1);
      rom[3] = aluInstr(opSub, 4, 3, 2);
      rom[4] = aluInstr(opAnd, 5, 4, 3);
      rom[5] = aluInstr(opXor, 6, 5, 4);
      rom[6] = haltWord;
      runProgram();
      // Load-use on rs and on store data, then the stored word read back
      rom[0] = loadByteImm(1, 40);
      rom[1] = loadByteImm(2, 9);
      rom[2] = immInstr(opSt, 2, 1, 2);
      rom[3] = immInstr(opLd, 3, 1, 2);
      rom[4] = aluInstr(opAdd, 4, 3, 2);
      rom[5] = immInstr(opLd, 5, 1, 2);
      rom[6] = immInstr(opSt, 5, 1, -1);
      rom[7] = immInstr(opLd, 6, 1, -1);
      rom[8] = haltWord;
      runProgram();
      // Stores and loads with negative offsets and wrap
      rom[0] = loadByteImm(1, 100);
      rom[1] = loadByteImm(2, 8'h55);
      rom[2] = loadByteImm(3, -2);
      rom[3] = immInstr(opSt, 2, 1, -16);
      rom[4] = immInstr(opSt, 3, 1, 15);
      rom[5] = immInstr(opSt, 1, 3, -1);
      rom[6] = immInstr(opLd, 4, 1, -16);
      rom[7] = immInstr(opLd, 5, 1, 15);
      rom[8] = immInstr(opLd, 6, 3, -1);
      rom[9] = haltWord;
      runProgram();
      // Read three slots after the write goes through the regfile bypass
      rom[0] = loadByteImm(1, 7);
      rom[3] = aluInstr(opAdd, 4, 1, 1);
      rom[4] = loadByteImm(1, -5);
      rom[7] = aluInstr(opSub, 5, 1, 4);
      rom[8] = haltWord;
      runProgram();
      // Nothing behind HALT may write
      rom[0] = loadByteImm(1, 1);
      rom[1] = immInstr(opAddi, 1, 1, 1);
      rom[2] = haltWord;
      rom[3] = loadByteImm(2, 99);
      rom[4] = loadByteImm(3, 98);
      runProgram();
      for (p = 0; p < randomPrograms; p++) begin
         makeRandomProgram();
         runProgram();
      end
      if (dut.chk.violations == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         reportFailure("the port checker flagged an assertion failure");
      end
   end

endmodule

`default_nettype wire

//--- proc16.f
+incdir+.
isaPkg.sv
pipePkg.sv
fetchStage.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memoryStage.sv
proc16.sv
proc16_checker.sv
proc16_tb.sv
